//--- hw/prefix_pkg.sv
package prefix_pkg;

    // legacy prefix byte values
    localparam logic [7:0] rep_code    = 8'hf3;
    localparam logic [7:0] seg_cs_code = 8'h2e;
    localparam logic [7:0] seg_ss_code = 8'h36;
    localparam logic [7:0] seg_ds_code = 8'h3e;
    localparam logic [7:0] seg_es_code = 8'h26;
    localparam logic [7:0] seg_fs_code = 8'h64;
    localparam logic [7:0] seg_gs_code = 8'h65;
    localparam logic [7:0] opsize_code = 8'h66;

    // byte queue geometry, 8 words of 4 bytes
    localparam int queue_depth = 32;
    localparam int queue_ptr_w = 5;

    // apb register map
    localparam int apb_addr_w = 4;
    localparam logic [apb_addr_w-1:0] addr_data   = 4'h0;  // write only
    localparam logic [apb_addr_w-1:0] addr_status = 4'h4;  // read only

    typedef logic [7:0] byte_t;

    // occupancy, needs one bit more than the pointer to reach 32
    typedef logic [queue_ptr_w:0] queue_count_t;

    // bit 0 cs, 1 ss, 2 ds, 3 es, 4 fs, 5 gs
    typedef logic [5:0] seg_onehot_t;

    typedef logic [1:0] prefix_count_t;

    // 0001 none, 0010 one, 0100 two, 1000 three
    typedef logic [3:0] prefix_onehot_t;

endpackage

//--- hw/prefix_cmp.sv
`timescale 1ns/1ps

module prefix_cmp (
    input  prefix_pkg::byte_t       prefix,
    output logic                    is_rep,
    output prefix_pkg::seg_onehot_t seg_override,
    output logic                    is_seg_override,
    output logic                    is_opsize_override,
    output logic                    hit
);

    // one equality match per known code
    assign is_rep             = (prefix == prefix_pkg::rep_code);
    assign is_opsize_override = (prefix == prefix_pkg::opsize_code);

    assign seg_override[0] = (prefix == prefix_pkg::seg_cs_code);
    assign seg_override[1] = (prefix == prefix_pkg::seg_ss_code);
    assign seg_override[2] = (prefix == prefix_pkg::seg_ds_code);
    assign seg_override[3] = (prefix == prefix_pkg::seg_es_code);
    assign seg_override[4] = (prefix == prefix_pkg::seg_fs_code);
    assign seg_override[5] = (prefix == prefix_pkg::seg_gs_code);

    assign is_seg_override = |seg_override;  // any of the six segments

    // byte is a prefix at all
    assign hit = is_rep | is_seg_override | is_opsize_override;

endmodule

//--- hw/apb_byte_writer.sv
`timescale 1ns/1ps

module apb_byte_writer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [prefix_pkg::apb_addr_w-1:0]   paddr,
    input  logic [31:0]                         pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  logic                                free_ok,
    input  prefix_pkg::queue_count_t            count,
    output logic                                push,
    output logic [31:0]                         push_data
);

    logic       access;
    logic       data_sel;
    logic       status_sel;
    logic       data_wr;
    logic       status_rd;
    logic       bad_access;
    logic [7:0] rej_cnt;

    assign access     = psel & penable;  // access phase
    assign data_sel   = (paddr == prefix_pkg::addr_data);
    assign status_sel = (paddr == prefix_pkg::addr_status);

    assign data_wr    = access & pwrite & data_sel;
    assign status_rd  = access & ~pwrite & status_sel;

    // wrong direction or unmapped offset
    assign bad_access = access & ~data_wr & ~status_rd;

    // data writes wait for room, everything else completes at once
    assign pready  = data_wr ? free_ok : access;
    assign pslverr = bad_access;

    assign push      = data_wr & free_ok;  // completing data write
    assign push_data = pwdata;             // byte 0 in bits 7:0

    always_comb begin
        prdata = '0;
        if (status_rd) begin
            prdata[5:0]  = count;
            prdata[15:8] = rej_cnt;
        end
    end

    // rejected access counter, sticks at 255
    always_ff @(posedge clk) begin
        if (rst) begin
            rej_cnt <= '0;
        end else if (bad_access && rej_cnt != 8'hff) begin
            rej_cnt <= rej_cnt + 8'd1;
        end
    end

endmodule

//--- hw/byte_queue.sv
`timescale 1ns/1ps

module byte_queue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  logic [31:0]              push_data,
    input  logic                     pop,
    input  logic [2:0]               pop_len,
    output prefix_pkg::byte_t        win0,
    output prefix_pkg::byte_t        win1,
    output prefix_pkg::byte_t        win2,
    output prefix_pkg::byte_t        win3,
    output logic                     win_full,
    output logic                     free_ok,
    output prefix_pkg::queue_count_t count
);

    localparam int ptr_w = prefix_pkg::queue_ptr_w;

    prefix_pkg::byte_t mem [prefix_pkg::queue_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] rd_idx1;
    logic [ptr_w-1:0] rd_idx2;
    logic [ptr_w-1:0] rd_idx3;

    prefix_pkg::queue_count_t add_n;
    prefix_pkg::queue_count_t sub_n;

    // pointer arithmetic wraps at the depth
    assign rd_idx1 = rd_ptr + ptr_w'(1);
    assign rd_idx2 = rd_ptr + ptr_w'(2);
    assign rd_idx3 = rd_ptr + ptr_w'(3);

    // lookahead window, oldest byte first
    assign win0 = mem[rd_ptr];
    assign win1 = mem[rd_idx1];
    assign win2 = mem[rd_idx2];
    assign win3 = mem[rd_idx3];

    assign win_full = (count >= prefix_pkg::queue_count_t'(4));
    assign free_ok  = (count <= prefix_pkg::queue_count_t'(prefix_pkg::queue_depth - 4));

    assign add_n = push ? prefix_pkg::queue_count_t'(4) : '0;
    assign sub_n = pop ? prefix_pkg::queue_count_t'(pop_len) : '0;

    // storage, four bytes per push
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < 4; i++) begin
                mem[wr_ptr + ptr_w'(i)] <= push_data[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + ptr_w'(4);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + ptr_w'(pop_len);  // 1 to 4 bytes
            end
            count <= count + add_n - sub_n;  // push and pop may share an edge
        end
    end

endmodule

//--- hw/prefix_decoder.sv
`timescale 1ns/1ps

module prefix_decoder (
    input  logic                       clk,
    input  logic                       rst,
    input  prefix_pkg::byte_t          win0,
    input  prefix_pkg::byte_t          win1,
    input  prefix_pkg::byte_t          win2,
    input  prefix_pkg::byte_t          win3,
    input  logic                       win_full,
    output logic                       pop,
    output logic [2:0]                 pop_len,
    output logic                       dec_valid,
    input  logic                       dec_ready,
    output prefix_pkg::prefix_count_t  num_prefixes_encoded,
    output prefix_pkg::prefix_onehot_t num_prefixes_onehot,
    output logic                       is_rep,
    output prefix_pkg::seg_onehot_t    seg_override,
    output logic                       is_seg_override,
    output logic                       is_opsize_override,
    output prefix_pkg::byte_t          opcode
);

    logic rep0, rep1, rep2;
    logic segf0, segf1, segf2;
    logic ops0, ops1, ops2;
    logic hit0, hit1, hit2;
    logic use1, use2;

    prefix_pkg::seg_onehot_t   seg0, seg1, seg2;
    prefix_pkg::prefix_count_t cnt;
    prefix_pkg::seg_onehot_t   seg_m;
    prefix_pkg::byte_t         opc;

    prefix_cmp cmp0 (
        .prefix             (win0),
        .is_rep             (rep0),
        .seg_override       (seg0),
        .is_seg_override    (segf0),
        .is_opsize_override (ops0),
        .hit                (hit0)
    );

    prefix_cmp cmp1 (
        .prefix             (win1),
        .is_rep             (rep1),
        .seg_override       (seg1),
        .is_seg_override    (segf1),
        .is_opsize_override (ops1),
        .hit                (hit1)
    );

    prefix_cmp cmp2 (
        .prefix             (win2),
        .is_rep             (rep2),
        .seg_override       (seg2),
        .is_seg_override    (segf2),
        .is_opsize_override (ops2),
        .hit                (hit2)
    );

    // byte 1 counts only behind a prefix in byte 0, byte 2 behind both
    assign use1 = hit0;
    assign use2 = hit0 & hit1;

    assign cnt = !hit0 ? 2'd0 : !hit1 ? 2'd1 : !hit2 ? 2'd2 : 2'd3;

    assign seg_m = seg0 | (seg1 & {6{use1}}) | (seg2 & {6{use2}});

    always_comb begin
        case (cnt)
            2'd0:    opc = win0;
            2'd1:    opc = win1;
            2'd2:    opc = win2;
            default: opc = win3;  // three prefixes, a fourth one lands here
        endcase
    end

    // take a head when the output slot is free or being drained
    assign pop     = win_full & (~dec_valid | dec_ready);
    assign pop_len = {1'b0, cnt} + 3'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (pop) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    // result held until the next pop
    always_ff @(posedge clk) begin
        if (pop) begin
            num_prefixes_encoded <= cnt;
            num_prefixes_onehot  <= prefix_pkg::prefix_onehot_t'(1) << cnt;
            is_rep               <= rep0 | (rep1 & use1) | (rep2 & use2);
            seg_override         <= seg_m;
            is_seg_override      <= segf0 | (segf1 & use1) | (segf2 & use2);
            is_opsize_override   <= ops0 | (ops1 & use1) | (ops2 & use2);
            opcode               <= opc;
        end
    end

endmodule

//--- hw/x86_prefix_frontend.sv
`timescale 1ns/1ps

module x86_prefix_frontend (
    input  logic                              clk,
    input  logic                              rst,
    // apb slave
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [prefix_pkg::apb_addr_w-1:0] paddr,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,
    // decoded head
    output logic                              dec_valid,
    input  logic                              dec_ready,
    output prefix_pkg::prefix_count_t         num_prefixes_encoded,
    output prefix_pkg::prefix_onehot_t        num_prefixes_onehot,
    output logic                              is_rep,
    output prefix_pkg::seg_onehot_t           seg_override,
    output logic                              is_seg_override,
    output logic                              is_opsize_override,
    output prefix_pkg::byte_t                 opcode
);

    logic                     push;
    logic [31:0]              push_data;
    logic                     free_ok;
    prefix_pkg::queue_count_t count;
    prefix_pkg::byte_t        win0, win1, win2, win3;
    logic                     win_full;
    logic                     pop;
    logic [2:0]               pop_len;

    apb_byte_writer writer_i (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .free_ok   (free_ok),
        .count     (count),
        .push      (push),
        .push_data (push_data)
    );

    byte_queue queue_i (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_len   (pop_len),
        .win0      (win0),
        .win1      (win1),
        .win2      (win2),
        .win3      (win3),
        .win_full  (win_full),
        .free_ok   (free_ok),
        .count     (count)
    );

    prefix_decoder decoder_i (
        .clk                  (clk),
        .rst                  (rst),
        .win0                 (win0),
        .win1                 (win1),
        .win2                 (win2),
        .win3                 (win3),
        .win_full             (win_full),
        .pop                  (pop),
        .pop_len              (pop_len),
        .dec_valid            (dec_valid),
        .dec_ready            (dec_ready),
        .num_prefixes_encoded (num_prefixes_encoded),
        .num_prefixes_onehot  (num_prefixes_onehot),
        .is_rep               (is_rep),
        .seg_override         (seg_override),
        .is_seg_override      (is_seg_override),
        .is_opsize_override   (is_opsize_override),
        .opcode               (opcode)
    );

endmodule

//--- verification/prefix_frontend_props.sv
`timescale 1ns/1ps

module prefix_frontend_props (
    input logic                              clk,
    input logic                              rst,
    input logic                              psel,
    input logic [prefix_pkg::apb_addr_w-1:0] paddr,
    input logic                              pready,
    input logic                              dec_valid,
    input logic                              dec_ready,
    input prefix_pkg::prefix_count_t         num_prefixes_encoded,
    input prefix_pkg::prefix_onehot_t        num_prefixes_onehot,
    input logic                              is_rep,
    input prefix_pkg::seg_onehot_t           seg_override,
    input logic                              is_seg_override,
    input logic                              is_opsize_override,
    input prefix_pkg::byte_t                 opcode
);

    pready_after_reset: assert property (@(posedge clk) rst |=> !pready)
        else $error("pready high right after reset");

    // master keeps the request until the slave answers
    apb_request_held: assert property (@(posedge clk) disable iff (rst)
        psel && !pready |=> psel && $stable(paddr))
        else $error("psel or paddr changed before pready");

    out_held: assert property (@(posedge clk) disable iff (rst)
        dec_valid && !dec_ready |=> dec_valid && $stable(opcode) && $stable(is_rep)
            && $stable(seg_override) && $stable(is_seg_override)
            && $stable(is_opsize_override) && $stable(num_prefixes_encoded)
            && $stable(num_prefixes_onehot))
        else $error("decoder output changed while stalled");

    onehot_matches: assert property (@(posedge clk) disable iff (rst)
        dec_valid |-> $onehot(num_prefixes_onehot)
            && num_prefixes_onehot == (4'b0001 << num_prefixes_encoded))
        else $error("one-hot prefix count disagrees with encoded count");

endmodule

//--- verification/tb_prefix_frontend.sv
`timescale 1ns/1ps

module tb_prefix_frontend;

    localparam int max_wait = 200;  // cycles

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [3:0]                 paddr;
    logic [31:0]                pwdata;
    logic [31:0]                prdata;
    logic                       pready;
    logic                       pslverr;
    logic                       dec_valid;
    logic                       dec_ready;
    prefix_pkg::prefix_count_t  num_prefixes_encoded;
    prefix_pkg::prefix_onehot_t num_prefixes_onehot;
    logic                       is_rep;
    prefix_pkg::seg_onehot_t    seg_override;
    logic                       is_seg_override;
    logic                       is_opsize_override;
    prefix_pkg::byte_t          opcode;

    logic [31:0]       lfsr;
    prefix_pkg::byte_t ref_q [$];     // written but not yet taken by a transfer
    prefix_pkg::byte_t directed [24];
    int                ready_mode;    // 0 ready, 1 random stalls, 2 held low
    int                rej_exp;
    int                n_out = 0;
    int                occ;
    bit                passed = 1'b0;
    bit                fail_shown = 1'b0;

    x86_prefix_frontend x86_prefix_frontend_i (.*);

    bind x86_prefix_frontend prefix_frontend_props props_i (.*);

    always #20 clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic prefix_pkg::seg_onehot_t seg_bit(input prefix_pkg::byte_t b);
        case (b)
            prefix_pkg::seg_cs_code: return 6'b000001;
            prefix_pkg::seg_ss_code: return 6'b000010;
            prefix_pkg::seg_ds_code: return 6'b000100;
            prefix_pkg::seg_es_code: return 6'b001000;
            prefix_pkg::seg_fs_code: return 6'b010000;
            prefix_pkg::seg_gs_code: return 6'b100000;
            default:                 return 6'b000000;
        endcase
    endfunction

    // none, one, two or three prefixes
    function automatic prefix_pkg::prefix_onehot_t onehot_of_count(input int n);
        case (n)
            0:       return 4'b0001;
            1:       return 4'b0010;
            2:       return 4'b0100;
            default: return 4'b1000;
        endcase
    endfunction

    function automatic logic is_prefix(input prefix_pkg::byte_t b);
        return b == prefix_pkg::rep_code || b == prefix_pkg::opsize_code || seg_bit(b) != 0;
    endfunction

    function automatic prefix_pkg::byte_t rand_byte();
        logic [2:0] idx;
        if (rand_bits(2) == 32'd0)
            return 8'(rand_bits(8));  // one time in four
        idx = 3'(rand_bits(3));
        case (idx)
            3'd0:    return prefix_pkg::rep_code;
            3'd1:    return prefix_pkg::opsize_code;
            3'd2:    return prefix_pkg::seg_cs_code;
            3'd3:    return prefix_pkg::seg_ss_code;
            3'd4:    return prefix_pkg::seg_ds_code;
            3'd5:    return prefix_pkg::seg_es_code;
            3'd6:    return prefix_pkg::seg_fs_code;
            default: return prefix_pkg::seg_gs_code;
        endcase
    endfunction

    // decodes the head of ref_q and with drop set removes count plus one bytes
    function automatic prefix_pkg::prefix_count_t ref_decode(
        input  bit                      drop,
        output logic                    rep,
        output prefix_pkg::seg_onehot_t seg,
        output logic                    ops,
        output prefix_pkg::byte_t       opc
    );
        int n;
        n   = 0;
        rep = 1'b0;
        seg = '0;
        ops = 1'b0;
        while (n < 3 && is_prefix(ref_q[n])) begin
            rep |= (ref_q[n] == prefix_pkg::rep_code);
            ops |= (ref_q[n] == prefix_pkg::opsize_code);
            seg |= seg_bit(ref_q[n]);
            n++;
        end
        opc = ref_q[n];
        if (drop)
            repeat (n + 1) void'(ref_q.pop_front());
        return prefix_pkg::prefix_count_t'(n);
    endfunction

    // bytes the dut still queues without the head held in its output register
    function automatic int dut_occupancy();
        logic                    r;
        logic                    o;
        prefix_pkg::seg_onehot_t s;
        prefix_pkg::byte_t       c;
        int                      held;
        held = 0;
        if (dec_valid)
            held = int'(ref_decode(1'b0, r, s, o, c)) + 1;
        return ref_q.size() - held;
    endfunction

    task automatic fail_stop(input string why);
        fail_shown = 1'b1;
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_count(input string name, input prefix_pkg::prefix_count_t got, exp);
        if (got !== exp)
            fail_stop($sformatf("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic check_onehot(input string name, input prefix_pkg::prefix_onehot_t got, exp);
        if (got !== exp)
            fail_stop($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_seg(input string name, input prefix_pkg::seg_onehot_t got, exp);
        if (got !== exp)
            fail_stop($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp)
            fail_stop($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_byte(input string name, input prefix_pkg::byte_t got, exp);
        if (got !== exp)
            fail_stop($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
        int waited;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pready && waited < max_wait) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            fail_stop("APB access never completed, pready stayed low");
        end else begin
            rdata = prdata;
            err   = pslverr;
            @(posedge clk);  // completing edge
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic write_word(input logic [31:0] w);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, prefix_pkg::addr_data, w, rd, err);
        check_flag("pslverr", err, 1'b0);
        for (int i = 0; i < 4; i++)
            ref_q.push_back(w[8*i +: 8]);  // byte 0 first
    endtask

    task automatic check_status(output int occ_now);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, prefix_pkg::addr_status, 32'h0, rd, err);
        occ_now = dut_occupancy();
        check_flag("pslverr", err, 1'b0);
        check_byte("status count", {2'b00, rd[5:0]}, 8'(occ_now));
        check_byte("status rejected", rd[15:8], 8'(rej_exp));
    endtask

    task automatic bad_access(input logic wr, input logic [3:0] addr);
        logic [31:0] rd;
        logic        err;
        apb_access(wr, addr, 32'h9090_9090, rd, err);
        check_flag("pslverr", err, 1'b1);
        rej_exp++;
    endtask

    task automatic drive_ready();
        forever begin
            @(posedge clk);
            if (ready_mode == 0)
                dec_ready <= 1'b1;
            else if (ready_mode == 1)
                dec_ready <= (rand_bits(2) != 32'd0);  // low about one cycle in four
            else
                dec_ready <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (ref_q.size() >= 4 && waited < max_wait) begin
            @(posedge clk);
            waited++;
        end
        if (ref_q.size() >= 4) begin
            fail_stop("no decoder output arrived for the bytes written");
        end else begin
            repeat (2) @(negedge clk);
            if (dec_valid)
                fail_stop("decoder shows an output after the stream ran dry");
        end
    endtask

    // each valid and ready edge is checked half a cycle ahead
    always @(negedge clk) begin : compare
        prefix_pkg::prefix_count_t cnt;
        prefix_pkg::seg_onehot_t   seg;
        prefix_pkg::byte_t         opc;
        logic                      rep;
        logic                      ops;
        if (!rst && dec_valid && dec_ready) begin
            if (ref_q.size() < 4) begin
                fail_stop("decoder output with no complete head written");
            end else begin
                cnt = ref_decode(1'b1, rep, seg, ops, opc);
                check_count("num_prefixes_encoded", num_prefixes_encoded, cnt);
                check_onehot("num_prefixes_onehot", num_prefixes_onehot,
                             onehot_of_count(int'(cnt)));
                check_flag("is_rep", is_rep, rep);
                check_seg("seg_override", seg_override, seg);
                check_flag("is_seg_override", is_seg_override, |seg);
                check_flag("is_opsize_override", is_opsize_override, ops);
                check_byte("opcode", opcode, opc);
                n_out++;
            end
        end
    end

    final begin
        if (!passed && !fail_shown)
            $display("Test failures found");
    end

    initial begin
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        dec_ready  = 1'b0;
        lfsr       = 32'hd24f_daf1;
        ready_mode = 0;
        rej_exp    = 0;
        // 0 to 3 prefixes, a fourth prefix as opcode, repeated and mixed segments
        directed = '{8'h90, 8'h66, 8'h89, 8'hf3, 8'h2e, 8'ha4, 8'h26, 8'h64,
                     8'h66, 8'h0f, 8'h3e, 8'h36, 8'h65, 8'h2e, 8'h2e, 8'h2e,
                     8'h3e, 8'h8b, 8'h64, 8'h65, 8'hf3, 8'hab, 8'h90, 8'h90};
        fork
            drive_ready();
        join_none
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 24; i += 4)
            write_word({directed[i+3], directed[i+2], directed[i+1], directed[i]});
        wait_drain();
        if (n_out != 7)
            fail_stop($sformatf("expected 7 directed heads, saw %0d", n_out));

        ready_mode = 1;
        repeat (150) write_word({rand_byte(), rand_byte(), rand_byte(), rand_byte()});
        wait_drain();

        // hold the output, then fill the queue
        ready_mode = 2;
        repeat (4) @(posedge clk);
        check_status(occ);
        bad_access(1'b0, prefix_pkg::addr_data);
        bad_access(1'b1, prefix_pkg::addr_status);
        bad_access(1'b1, 4'hc);
        check_status(occ);
        for (int k = 0; k < 12 && occ <= 28; k++) begin
            write_word({rand_byte(), rand_byte(), rand_byte(), rand_byte()});
            check_status(occ);
        end
        if (occ <= 28)
            fail_stop("queue never filled past 28 bytes while the decoder was held");
        fork
            write_word({rand_byte(), rand_byte(), rand_byte(), rand_byte()});
            begin
                repeat (10) @(negedge clk);
                if (!(psel && penable && !pready))
                    fail_stop("write to a full queue did not wait for room");
                else
                    ready_mode = 1;
            end
        join
        wait_drain();
        check_status(occ);

        passed = 1'b1;
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- tb.f
hw/prefix_pkg.sv
hw/prefix_cmp.sv
hw/apb_byte_writer.sv
hw/byte_queue.sv
hw/prefix_decoder.sv
hw/x86_prefix_frontend.sv
verification/prefix_frontend_props.sv
verification/tb_prefix_frontend.sv

//--- Makefile
TOP        ?= tb_prefix_frontend
VERILATOR  ?= verilator
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
